/* common/exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

////////////////////////////////////////////////////////////
// execute stage widths
////////////////////////////////////////////////////////////

`define EXE_XLEN        32      // data path
`define EXE_REG_AW      5       // architectural register number

////////////////////////////////////////////////////////////
// timing and exception codes
////////////////////////////////////////////////////////////

// start edge to done, one cycle per quotient bit plus entry
`define EXE_DIV_CYCLES  33

`define EXE_ECODE_ALE   6'h09   // address not aligned

`endif

/* common/exe_types_pkg.sv */
`default_nettype none

`include "exe_consts.svh"

package exe_types_pkg;
    import mem_types_pkg::*;

    typedef logic [`EXE_XLEN-1:0]   word_t;
    typedef logic [`EXE_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        div_none = 3'd0,
        div_w    = 3'd1,
        mod_w    = 3'd2,
        div_wu   = 3'd3,
        mod_wu   = 3'd4
    } div_op_e;

    // decoded instruction from the issue stage
    typedef struct packed {
        word_t      pc;
        alu_op_e    alu_op;
        div_op_e    div_op;
        logic       src1_is_pc;
        logic       src2_is_imm;
        word_t      imm;
        word_t      rj_value;
        word_t      rkd_value;
        reg_addr_t  dest;
        logic       gr_we;
        logic       mem_load;
        logic       mem_store;
        mem_width_e mem_width;
        logic       ld_unsigned;    // zero extend on load
    } exe_issue_t;

    // handed to the memory stage
    typedef struct packed {
        word_t      pc;
        word_t      result;     // alu/div value, or the address for memory ops
        reg_addr_t  dest;
        logic       gr_we;
        logic       mem_load;
        mem_width_e mem_width;
        logic       ld_unsigned;
        logic [1:0] mem_off;    // byte offset for load alignment
        logic       ale;
        logic [5:0] ecode;
    } exe_result_t;

endpackage

`default_nettype wire

/* common/mem_types_pkg.sv */
`default_nettype none

`include "exe_consts.svh"

package mem_types_pkg;

    // access width, same code as the bus size field
    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_width_e;

    typedef logic [3:0] strobe_t;   // one bit per byte lane

    // data memory request, 71 bits
    typedef struct packed {
        logic                  wr;      // store when set
        mem_width_e            size;
        strobe_t               wstrb;
        logic [`EXE_XLEN-1:0]  addr;
        logic [`EXE_XLEN-1:0]  wdata;
    } data_req_t;

endpackage

`default_nettype wire

/* div/exe_divider.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exe_consts.svh"

module exe_divider
    import exe_types_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  div_op_e div_op,
    input  word_t   dividend,
    input  word_t   divisor,
    output word_t   div_result,
    output logic    div_done
);

    localparam logic [5:0] last_step = 6'(`EXE_DIV_CYCLES - 2);

    typedef enum logic [1:0] {st_idle, st_run, st_done} div_state_e;

    div_state_e  state;
    logic [5:0]  step_cnt;
    word_t       rem_q;
    word_t       quo_q;
    word_t       dvd_mag;
    word_t       dvs_mag;
    word_t       cur_rem;
    word_t       cur_quo;
    word_t       quo_fix;
    word_t       rem_fix;
    logic [33:0] trial;
    logic        is_signed;
    logic        want_rem;
    logic        dvd_neg;
    logic        dvs_neg;
    logic        div_zero;

    // operands stay put in the stage register while we iterate
    assign is_signed = (div_op == div_w) || (div_op == mod_w);
    assign want_rem  = (div_op == mod_w) || (div_op == mod_wu);
    assign dvd_neg   = is_signed && dividend[`EXE_XLEN-1];
    assign dvs_neg   = is_signed && divisor[`EXE_XLEN-1];
    assign dvd_mag   = dvd_neg ? -dividend : dividend;
    assign dvs_mag   = dvs_neg ? -divisor : divisor;
    assign div_zero  = (divisor == '0);

    // step 0 works straight from the operands
    assign cur_rem = (step_cnt == '0) ? '0 : rem_q;
    assign cur_quo = (step_cnt == '0) ? dvd_mag : quo_q;
    assign trial   = {1'b0, cur_rem, cur_quo[`EXE_XLEN-1]} - {2'b00, dvs_mag};

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                st_run: begin
                    step_cnt <= step_cnt + 6'd1;
                    if (step_cnt == last_step) begin
                        state <= st_done;
                    end
                end
                default: begin      // idle or done, wait for the next divide
                    if (start) begin
                        state    <= st_run;
                        step_cnt <= '0;
                    end
                end
            endcase
        end
    end

    // one quotient bit per cycle, restoring
    always_ff @(posedge clk) begin
        if (state == st_run) begin
            if (trial[33]) begin
                rem_q <= {cur_rem[`EXE_XLEN-2:0], cur_quo[`EXE_XLEN-1]};
                quo_q <= {cur_quo[`EXE_XLEN-2:0], 1'b0};
            end else begin
                rem_q <= trial[`EXE_XLEN-1:0];
                quo_q <= {cur_quo[`EXE_XLEN-2:0], 1'b1};
            end
        end
    end

    // sign fix, remainder follows the dividend
    assign quo_fix = (dvd_neg ^ dvs_neg) ? -quo_q : quo_q;
    assign rem_fix = dvd_neg ? -rem_q : rem_q;

    always_comb begin
        if (div_zero) begin
            div_result = want_rem ? dividend : '1;
        end else begin
            div_result = want_rem ? rem_fix : quo_fix;
        end
    end

    assign div_done = (state == st_done);

endmodule

`default_nettype wire

/* hw/exe_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_alu
    import exe_types_pkg::*;
(
    input  exe_issue_t issue,
    output word_t      src1,
    output word_t      src2,
    output word_t      alu_result
);

    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;

    // operand muxes
    assign src1 = issue.src1_is_pc  ? issue.pc  : issue.rj_value;
    assign src2 = issue.src2_is_imm ? issue.imm : issue.rkd_value;

    assign shamt       = src2[4:0];
    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = ($signed(src1) < $signed(src2));
    assign lt_unsigned = (src1 < src2);

    ////////////////////////////////////////////////////////////
    // operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.alu_op)
            alu_add:  alu_result = sum;     // also the load/store address
            alu_sub:  alu_result = diff;
            alu_slt:  alu_result = word_t'(lt_signed);
            alu_sltu: alu_result = word_t'(lt_unsigned);
            alu_and:  alu_result = src1 & src2;
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_sll:  alu_result = src1 << shamt;
            alu_srl:  alu_result = src1 >> shamt;
            alu_sra:  alu_result = word_t'($signed(src1) >>> shamt);
            alu_lui:  alu_result = src2;    // immediate already shifted by decode
            default:  alu_result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* hw/exe_pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exe_consts.svh"

module exe_pipe_reg
    import exe_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  exe_issue_t  in_bus,
    output logic        in_allowin,
    output logic        out_valid,
    input  logic        out_allowin,
    output exe_result_t out_bus,
    output exe_issue_t  issue,
    output logic        stage_valid,
    output logic        accept,
    input  word_t       alu_result,
    input  word_t       div_result,
    input  logic        div_done,
    input  logic        mem_done,
    input  logic        ale
);

    logic is_div;
    logic is_mem;
    logic ready_go;

    assign is_div = (issue.div_op != div_none);
    assign is_mem = issue.mem_load | issue.mem_store;

    // divides wait for the divider, memory ops for the bus or an ALE
    assign ready_go = is_div ? div_done :
                      is_mem ? mem_done : 1'b1;

    assign in_allowin = !stage_valid || (ready_go && out_allowin);
    assign out_valid  = stage_valid && ready_go;
    assign accept     = in_valid && in_allowin;

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (in_allowin) begin
            stage_valid <= in_valid;    // empty when nothing arrives
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue <= in_bus;
        end
    end

    ////////////////////////////////////////////////////////////
    // result bus
    ////////////////////////////////////////////////////////////

    always_comb begin
        out_bus.pc          = issue.pc;
        out_bus.result      = is_div ? div_result : alu_result;
        out_bus.dest        = issue.dest;
        out_bus.gr_we       = issue.gr_we;
        out_bus.mem_load    = issue.mem_load;
        out_bus.mem_width   = issue.mem_width;
        out_bus.ld_unsigned = issue.ld_unsigned;
        out_bus.mem_off     = alu_result[1:0];
        out_bus.ale         = ale;
        out_bus.ecode       = ale ? `EXE_ECODE_ALE : 6'h00;
    end

endmodule

`default_nettype wire

/* hw/exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_stage
    import mem_types_pkg::*;
    import exe_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    // from issue
    input  logic        in_valid,
    input  exe_issue_t  in_bus,
    output logic        in_allowin,
    // to memory stage
    output logic        out_valid,
    input  logic        out_allowin,
    output exe_result_t out_bus,
    // data memory request
    output logic        data_req,
    output data_req_t   data_req_bus,
    input  logic        data_addr_ok
);

    exe_issue_t issue;
    logic       stage_valid;
    logic       accept;
    word_t      src1;
    word_t      src2;
    word_t      alu_result;
    word_t      div_result;
    logic       div_done;
    logic       mem_done;
    logic       ale;

    // divider only kicks off for divide/modulo instructions
    wire div_start = accept && (in_bus.div_op != div_none);

    exe_pipe_reg u_pipe_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_allowin (out_allowin),
        .out_bus     (out_bus),
        .issue       (issue),
        .stage_valid (stage_valid),
        .accept      (accept),
        .alu_result  (alu_result),
        .div_result  (div_result),
        .div_done    (div_done),
        .mem_done    (mem_done),
        .ale         (ale)
    );

    exe_alu u_alu (
        .issue      (issue),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result)
    );

    exe_divider u_divider (
        .clk        (clk),
        .reset      (reset),
        .start      (div_start),
        .div_op     (issue.div_op),
        .dividend   (src1),
        .divisor    (src2),
        .div_result (div_result),
        .div_done   (div_done)
    );

    lsu_req_gen u_lsu_req (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .stage_valid  (stage_valid),
        .accept       (accept),
        .addr         (alu_result),     // effective address from the adder
        .out_allowin  (out_allowin),
        .data_req     (data_req),
        .data_req_bus (data_req_bus),
        .data_addr_ok (data_addr_ok),
        .mem_done     (mem_done),
        .ale          (ale)
    );

endmodule

`default_nettype wire

/* hw/lsu_req_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_req_gen
    import mem_types_pkg::*;
    import exe_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  exe_issue_t issue,
    input  logic       stage_valid,
    input  logic       accept,
    input  word_t      addr,
    input  logic       out_allowin,
    output logic       data_req,
    output data_req_t  data_req_bus,
    input  logic       data_addr_ok,
    output logic       mem_done,
    output logic       ale
);

    logic    is_mem;
    logic    misaligned;
    logic    sent;
    strobe_t strb;
    word_t   wdata;

    assign is_mem = issue.mem_load | issue.mem_store;

    // lane strobe, replicated store data, alignment
    always_comb begin
        case (issue.mem_width)
            mem_byte: begin
                strb       = strobe_t'(4'b0001 << addr[1:0]);
                wdata      = {4{issue.rkd_value[7:0]}};
                misaligned = 1'b0;
            end
            mem_half: begin
                strb       = strobe_t'(4'b0011 << addr[1:0]);
                wdata      = {2{issue.rkd_value[15:0]}};
                misaligned = addr[0];
            end
            default: begin
                strb       = 4'b1111;
                wdata      = issue.rkd_value;
                misaligned = (addr[1:0] != 2'b00);
            end
        endcase
    end

    assign ale = stage_valid && is_mem && misaligned;

    // only ask while downstream can take the instruction
    assign data_req = stage_valid && is_mem && !misaligned && !sent && out_allowin;
    assign mem_done = ale || sent || (data_req && data_addr_ok);

    always_ff @(posedge clk) begin
        if (reset) begin
            sent <= 1'b0;
        end else if (accept) begin
            sent <= 1'b0;   // fresh instruction
        end else if (data_req && data_addr_ok) begin
            sent <= 1'b1;
        end
    end

    always_comb begin
        data_req_bus.wr    = issue.mem_store;
        data_req_bus.size  = issue.mem_width;
        data_req_bus.wstrb = strb;
        data_req_bus.addr  = addr;
        data_req_bus.wdata = wdata;
    end

endmodule

`default_nettype wire

/* verification/tb_exe_ref.svh */
`ifndef TB_EXE_REF_SVH
`define TB_EXE_REF_SVH

////////////////////////////////////////////////////////////
// reference model of the execute stage
////////////////////////////////////////////////////////////

function automatic word_t operand_a(exe_issue_t i);
    return i.src1_is_pc ? i.pc : i.rj_value;
endfunction

function automatic word_t operand_b(exe_issue_t i);
    return i.src2_is_imm ? i.imm : i.rkd_value;
endfunction

function automatic logic is_mem_op(exe_issue_t i);
    return i.mem_load || i.mem_store;
endfunction

function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    logic [4:0]  sh;
    logic [63:0] ext;
    sh  = b[4:0];
    ext = {{32{a[31]}}, a};    // sign filled for sra
    case (op)
        alu_add:  return a + b;
        alu_sub:  return a + ~b + 32'd1;
        alu_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        alu_sltu: return {31'd0, a < b};
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_nor:  return ~a & ~b;
        alu_sll:  return a << sh;
        alu_srl:  return a >> sh;
        alu_sra:  return word_t'(ext >> sh);
        alu_lui:  return b;
        default:  return '0;
    endcase
endfunction

// 64 bit math covers min / -1 without overflow
function automatic word_t ref_div(div_op_e op, word_t a, word_t b);
    logic   sgn;
    logic   rem;
    longint sa;
    longint sb;
    sgn = (op == div_w) || (op == mod_w);
    rem = (op == mod_w) || (op == mod_wu);
    if (b == '0) begin
        return rem ? a : 32'hffff_ffff;
    end
    if (sgn) begin
        sa = longint'($signed(a));
        sb = longint'($signed(b));
    end else begin
        sa = longint'({32'd0, a});
        sb = longint'({32'd0, b});
    end
    return rem ? word_t'(sa % sb) : word_t'(sa / sb);
endfunction

function automatic logic addr_misaligned(exe_issue_t i, word_t addr);
    case (i.mem_width)
        mem_half: return is_mem_op(i) && addr[0];
        mem_word: return is_mem_op(i) && (addr[1:0] != 2'b00);
        default:  return 1'b0;
    endcase
endfunction

function automatic exe_result_t expect_result(exe_issue_t i);
    exe_result_t r;
    word_t       addr;
    addr          = operand_a(i) + operand_b(i);
    r.pc          = i.pc;
    r.dest        = i.dest;
    r.gr_we       = i.gr_we;
    r.mem_load    = i.mem_load;
    r.mem_width   = i.mem_width;
    r.ld_unsigned = i.ld_unsigned;
    if (i.div_op != div_none) begin
        r.result = ref_div(i.div_op, operand_a(i), operand_b(i));
    end else if (is_mem_op(i)) begin
        r.result = addr;
    end else begin
        r.result = ref_alu(i.alu_op, operand_a(i), operand_b(i));
    end
    r.mem_off = is_mem_op(i) ? addr[1:0] : 2'b00;   // only defined for memory ops
    r.ale     = addr_misaligned(i, addr);
    r.ecode   = r.ale ? `EXE_ECODE_ALE : 6'h00;
    return r;
endfunction

function automatic data_req_t expect_request(exe_issue_t i);
    data_req_t q;
    word_t     addr;
    int        k;
    addr   = operand_a(i) + operand_b(i);
    q.wr   = i.mem_store;
    q.size = i.mem_width;
    q.addr = addr;
    // one byte lane per pass
    for (k = 0; k < 4; k++) begin
        case (i.mem_width)
            mem_byte: begin
                q.wstrb[k]        = (k == int'(addr[1:0]));
                q.wdata[8*k +: 8] = i.rkd_value[7:0];
            end
            mem_half: begin
                q.wstrb[k]        = (k / 2 == int'(addr[1]));
                q.wdata[8*k +: 8] = i.rkd_value[8*(k%2) +: 8];
            end
            default: begin
                q.wstrb[k]        = 1'b1;
                q.wdata[8*k +: 8] = i.rkd_value[8*k +: 8];
            end
        endcase
    end
    return q;
endfunction

function automatic int expect_req_count(exe_issue_t i);
    return (is_mem_op(i) && !addr_misaligned(i, operand_a(i) + operand_b(i))) ? 1 : 0;
endfunction

// accept edge to first out_valid edge, 0 where it varies
function automatic int expect_latency(exe_issue_t i);
    if (i.div_op != div_none) begin
        return `EXE_DIV_CYCLES;
    end
    if (expect_req_count(i) == 1) begin
        return 0;
    end
    return 1;
endfunction

`endif

/* verification/tb_exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exe_consts.svh"

module tb_exe_stage
    import mem_types_pkg::*;
    import exe_types_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        in_valid;
    exe_issue_t  in_bus;
    logic        in_allowin;
    logic        out_valid;
    logic        out_allowin;
    exe_result_t out_bus;
    logic        data_req;
    data_req_t   data_req_bus;
    logic        data_addr_ok;

    exe_issue_t  stim[$];       // instructions still to send
    exe_issue_t  inflight[$];   // accepted, not yet handed on
    int          value_errs  = 0;
    int          proto_errs  = 0;
    int          out_count   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 200;
    int          accept_cycle = 0;
    int          req_count   = 0;
    logic        lat_pending = 1'b0;
    logic        hold_valid  = 1'b0;
    exe_result_t hold_bus;

    `include "tb_exe_ref.svh"

    exe_stage dut0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .in_allowin   (in_allowin),
        .out_valid    (out_valid),
        .out_allowin  (out_allowin),
        .out_bus      (out_bus),
        .data_req     (data_req),
        .data_req_bus (data_req_bus),
        .data_addr_ok (data_addr_ok)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus builders
    ////////////////////////////////////////////////////////////

    function automatic exe_issue_t base_issue();
        exe_issue_t i;
        i             = '0;
        i.pc          = $urandom() & 32'hffff_fffc;
        i.imm         = $urandom();
        i.rj_value    = $urandom();
        i.rkd_value   = $urandom();
        i.dest        = reg_addr_t'($urandom_range(0, 31));
        i.gr_we       = 1'($urandom_range(0, 1));
        i.mem_width   = mem_width_e'($urandom_range(0, 2));
        i.ld_unsigned = 1'($urandom_range(0, 1));
        i.alu_op      = alu_add;
        i.div_op      = div_none;
        return i;
    endfunction

    function automatic exe_issue_t make_alu();
        exe_issue_t i;
        i             = base_issue();
        i.alu_op      = alu_op_e'($urandom_range(0, 11));
        i.src1_is_pc  = 1'($urandom_range(0, 1));
        i.src2_is_imm = 1'($urandom_range(0, 1));
        return i;
    endfunction

    function automatic exe_issue_t make_div(div_op_e op, word_t a, word_t b);
        exe_issue_t i;
        i           = base_issue();
        i.div_op    = op;
        i.rj_value  = a;
        i.rkd_value = b;
        return i;
    endfunction

    function automatic word_t rand_operand();
        return $urandom() >> $urandom_range(0, 31);   // spread of magnitudes
    endfunction

    function automatic exe_issue_t make_mem(logic store, mem_width_e w, logic bad);
        exe_issue_t i;
        word_t      addr;
        logic [1:0] off;
        i   = base_issue();
        off = 2'($urandom_range(0, 3));
        case (w)
            mem_half: off[0] = bad;
            mem_word: off = bad ? 2'($urandom_range(1, 3)) : 2'b00;
            default:  ;
        endcase
        addr          = ($urandom() & 32'hffff_fffc) | word_t'(off);
        i.imm         = word_t'($urandom_range(0, 2047));
        i.rj_value    = addr - i.imm;   // base + offset lands on addr
        i.src2_is_imm = 1'b1;
        i.mem_load    = !store;
        i.mem_store   = store;
        i.mem_width   = w;
        return i;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare process, sampled mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare
        exe_issue_t  cur;
        exe_result_t exp_res;
        exe_result_t got_res;
        data_req_t   exp_req;
        data_req_t   got_req;
        if (!reset) begin
            assert (!(data_req && !out_allowin)) else begin
                proto_errs++;
                $display("data_req raised while out_allowin was low at %0t", $time);
            end
            // open when empty or when the held instruction leaves this edge
            assert (in_allowin == (inflight.size() == 0 || (out_valid && out_allowin))) else begin
                proto_errs++;
                $display("in_allowin did not follow the stage occupancy at %0t", $time);
            end
            if (hold_valid) begin
                assert (out_valid && out_bus == hold_bus) else begin
                    proto_errs++;
                    $display("out_bus changed or dropped during a stall at %0t", $time);
                end
            end
            hold_valid = out_valid && !out_allowin;
            hold_bus   = out_bus;
            if (inflight.size() > 0) begin
                cur = inflight[0];
                if (lat_pending && out_valid) begin
                    lat_pending = 1'b0;
                    if (expect_latency(cur) != 0) begin
                        assert (cycle_cnt - accept_cycle == expect_latency(cur)) else begin
                            value_errs++;
                            $display("** Error at %0t: latency for pc %h expected %0d got %0d",
                                     $time, cur.pc, expect_latency(cur),
                                     cycle_cnt - accept_cycle);
                        end
                    end
                end
                assert (!data_req || expect_req_count(cur) == 1) else begin
                    proto_errs++;
                    $display("data_req for an instruction with no access at %0t", $time);
                end
                if (data_req && data_addr_ok) begin
                    req_count++;
                    exp_req = expect_request(cur);
                    got_req = data_req_bus;
                    if (!cur.mem_store) begin
                        exp_req.wdata = '0;     // load data lanes unused
                        got_req.wdata = '0;
                    end
                    assert (got_req == exp_req) else begin
                        value_errs++;
                        $display("** Error at %0t: request expected %h got %h",
                                 $time, exp_req, got_req);
                    end
                end
            end else begin
                assert (!out_valid && !data_req) else begin
                    proto_errs++;
                    $display("output activity with an empty stage at %0t", $time);
                end
            end
            if (out_valid && out_allowin) begin
                assert (inflight.size() > 0) else begin
                    proto_errs++;
                    $display("result handed on with nothing accepted at %0t", $time);
                end
                if (inflight.size() > 0) begin
                    cur     = inflight.pop_front();
                    exp_res = expect_result(cur);
                    got_res = out_bus;
                    if (!is_mem_op(cur)) begin
                        got_res.mem_off = 2'b00;
                    end
                    assert (got_res == exp_res) else begin
                        value_errs++;
                        $display("** Error at %0t: pc %h result expected %h got %h",
                                 $time, cur.pc, exp_res, got_res);
                    end
                    assert (req_count == expect_req_count(cur)) else begin
                        proto_errs++;
                        $display("pc %h made %0d memory requests instead of %0d",
                                 cur.pc, req_count, expect_req_count(cur));
                    end
                    out_count++;
                end
            end
            if (in_valid && in_allowin) begin
                inflight.push_back(in_bus);
                accept_cycle = cycle_cnt;
                lat_pending  = 1'b1;
                req_count    = 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        int      seed_val;
        int      k;
        int      idx;
        int      n_calm;
        logic    took;
        logic    stalls;
        div_op_e d;
        seed_val     = $urandom(32'h4dd584fb);
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_bus       = '0;
        out_allowin  = 1'b1;
        data_addr_ok = 1'b1;

        for (k = 0; k < 60; k++) begin
            stim.push_back(make_alu());
        end
        for (k = 1; k <= 4; k++) begin
            d = div_op_e'(k);
            stim.push_back(make_div(d, $urandom(), 32'd0));
            repeat (4) stim.push_back(make_div(d, $urandom(), rand_operand()));
        end
        stim.push_back(make_div(div_w, 32'h8000_0000, 32'hffff_ffff));
        stim.push_back(make_div(mod_w, 32'h8000_0000, 32'hffff_ffff));
        for (k = 0; k < 32; k++) begin
            stim.push_back(make_mem(1'($urandom_range(0, 1)),
                                    mem_width_e'($urandom_range(0, 2)), 1'b0));
        end
        for (k = 0; k < 12; k++) begin
            stim.push_back(make_mem(1'($urandom_range(0, 1)),
                                    mem_width_e'($urandom_range(1, 2)), 1'b1));
        end
        n_calm = stim.size();
        for (k = 0; k < 60; k++) begin   // mixed traffic under stalls
            case ($urandom_range(0, 4))
                0, 1: stim.push_back(make_alu());
                2: stim.push_back(make_div(div_op_e'($urandom_range(1, 4)),
                                           $urandom(), rand_operand()));
                3: stim.push_back(make_mem(1'($urandom_range(0, 1)),
                                           mem_width_e'($urandom_range(0, 2)), 1'b0));
                default: stim.push_back(make_mem(1'($urandom_range(0, 1)),
                                                 mem_width_e'($urandom_range(1, 2)), 1'b1));
            endcase
        end
        cycle_limit = 40 * stim.size() + 200;

        repeat (3) @(posedge clk);
        #0.5;
        reset = 1'b0;

        idx = 0;
        while (out_count < stim.size()) begin
            @(negedge clk);
            took = in_valid && in_allowin;
            @(posedge clk);
            #0.5;
            if (took) begin
                idx++;
            end
            stalls = (idx >= n_calm);
            if (took || !in_valid) begin
                if (idx < stim.size() && (!stalls || $urandom_range(0, 3) != 0)) begin
                    in_valid = 1'b1;
                    in_bus   = stim[idx];
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_allowin  = !stalls || ($urandom_range(0, 2) != 0);
            data_addr_ok = !stalls || ($urandom_range(0, 2) != 0);
        end
        repeat (4) @(posedge clk);

        assert (inflight.size() == 0 && out_count == stim.size()) else begin
            proto_errs++;
            $display("instructions lost or left over at the end of the run");
        end
        $display("summary: %0d instructions, %0d value errors, %0d protocol errors",
                 stim.size(), value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
+incdir+verification
common/mem_types_pkg.sv
common/exe_types_pkg.sv
hw/exe_pipe_reg.sv
hw/exe_alu.sv
div/exe_divider.sv
hw/lsu_req_gen.sv
hw/exe_stage.sv
verification/tb_exe_stage.sv
